/* include/mmio_regs.svh */
// MMIO word offsets and the AFU identifier, included by the memory map and the testbench
`ifndef MMIO_REGS_SVH
`define MMIO_REGS_SVH

// ==============================
// register word offsets
// ==============================

// identifier register, read only
`define REG_ID 16'd0
// host byte address where the header lines start
`define REG_RD_ADDR 16'd1
// host byte address where the result lines go
`define REG_WR_ADDR 16'd2
// number of lines in one run, used for both channels
`define REG_SIZE 16'd3
// difficulty target, only the low hash bits are kept
`define REG_TARGET 16'd4
// any write here starts a run
`define REG_GO 16'd5
// live copy of the DMA write done level
`define REG_DONE 16'd6

// value returned by REG_ID so software can tell it found the right AFU
`define AFU_ID_VALUE 64'h4E4F_4E43_4553_5231

`endif

/* verilog/miner_pkg.sv */
// shared widths, types, hash constants and result layout for the hash search AFU
package miner_pkg;

   // ==============================
   // widths and types
   // ==============================

   localparam int LINE_WIDTH = 64;
   localparam int ADDR_WIDTH = 64;
   localparam int SIZE_WIDTH = 16;
   localparam int NONCE_WIDTH = 16;
   localparam int HASH_WIDTH = 32;
   // MMIO registers are addressed by word index
   localparam int MMIO_ADDR_WIDTH = 16;

   typedef logic [LINE_WIDTH-1:0] line_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [SIZE_WIDTH-1:0] count_t;
   typedef logic [NONCE_WIDTH-1:0] nonce_t;
   typedef logic [HASH_WIDTH-1:0] hash_t;
   typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;

   // ==============================
   // hash and result layout
   // ==============================

   localparam int MIX_ROTATE = 29;
   localparam int MIX_ROUNDS = 2;
   // any odd constant keeps the multiply a bijection on 64 bits
   localparam line_t MIX_MULT = 64'h9E37_79B9_7F4A_7C15;

   // field positions inside one result line
   localparam int RES_FOUND_BIT = 63;
   localparam int RES_NONCE_LSB = 32;
   localparam int RES_HASH_LSB = 0;

   // a lane waits for a job, searches, then holds its result until taken
   typedef enum logic [1:0] {
      LANE_IDLE,
      LANE_SEARCH,
      LANE_HOLD
   } lane_state_t;

   // the nonce lands in the low bits of the header before the rounds
   function automatic hash_t mix_hash(line_t header, nonce_t nonce);
      line_t v;
      v = header ^ {{(LINE_WIDTH-NONCE_WIDTH){1'b0}}, nonce};
      for (int r = 0; r < MIX_ROUNDS; r++) begin
         // xor with a right rotation, then spread the bits with the multiply
         v = v ^ {v[MIX_ROTATE-1:0], v[LINE_WIDTH-1:MIX_ROTATE]};
         v = v * MIX_MULT;
      end
      return v[HASH_WIDTH-1:0];
   endfunction

endpackage

/* verilog/memory_map.sv */
// MMIO register file of the AFU that holds the run setup and turns a go write into a pulse
`timescale 1ns/10ps

`include "mmio_regs.svh"

module memory_map (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   mmio_wr_en,
   input  miner_pkg::mmio_addr_t  mmio_wr_addr,
   input  miner_pkg::line_t       mmio_wr_data,
   input  logic                   mmio_rd_en,
   input  miner_pkg::mmio_addr_t  mmio_rd_addr,
   input  logic                   wr_done,
   output miner_pkg::line_t       mmio_rd_data,
   output logic                   mmio_rd_valid,
   output logic                   go,
   output miner_pkg::addr_t       rd_base,
   output miner_pkg::addr_t       wr_base,
   output miner_pkg::count_t      size,
   output miner_pkg::hash_t       target
);

   // ==============================
   // register writes
   // ==============================

   // the setup registers keep their value until software rewrites them
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_base <= '0;
         wr_base <= '0;
         size    <= '0;
         target  <= '0;
         go      <= 1'b0;
      end else begin
         // go only lasts for the cycle after the write
         go <= 1'b0;
         if (mmio_wr_en) begin
            case (mmio_wr_addr)
               `REG_RD_ADDR: rd_base <= mmio_wr_data;
               `REG_WR_ADDR: wr_base <= mmio_wr_data;
               // only the low bits of size and target are stored
               `REG_SIZE:    size <= mmio_wr_data[miner_pkg::SIZE_WIDTH-1:0];
               `REG_TARGET:  target <= mmio_wr_data[miner_pkg::HASH_WIDTH-1:0];
               // the data of a go write carries no meaning
               `REG_GO:      go <= 1'b1;
               default: ;
            endcase
         end
      end
   end

   // ==============================
   // register reads
   // ==============================

   // the valid flag follows every read request by exactly one cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         mmio_rd_valid <= 1'b0;
      end else begin
         mmio_rd_valid <= mmio_rd_en;
      end
   end

   // the read data register answers the word requested in the cycle before
   always_ff @(posedge clk) begin
      if (mmio_rd_en) begin
         case (mmio_rd_addr)
            `REG_ID:      mmio_rd_data <= `AFU_ID_VALUE;
            `REG_RD_ADDR: mmio_rd_data <= rd_base;
            `REG_WR_ADDR: mmio_rd_data <= wr_base;
            `REG_SIZE:    mmio_rd_data <= miner_pkg::line_t'(size);
            `REG_TARGET:  mmio_rd_data <= miner_pkg::line_t'(target);
            // done is sampled live so software sees the DMA state directly
            `REG_DONE:    mmio_rd_data <= miner_pkg::line_t'(wr_done);
            default:      mmio_rd_data <= '0;
         endcase
      end
   end

   // every read answer belongs to a request from the cycle before and carries defined data
   assert property (@(posedge clk) disable iff (rst)
      mmio_rd_valid |-> $past(mmio_rd_en) && !$isunknown(mmio_rd_data));

endmodule

/* verilog/job_dispatch.sv */
// moves header lines from the DMA read channel into the search lanes in round-robin order
`timescale 1ns/10ps

module job_dispatch #(
   parameter int NUM_LANES = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  go,
   input  miner_pkg::addr_t      rd_base,
   input  miner_pkg::count_t     size,
   input  miner_pkg::line_t      rd_data,
   input  logic                  empty,
   input  logic [NUM_LANES-1:0]  lane_idle,
   output miner_pkg::addr_t      rd_addr,
   output miner_pkg::count_t     rd_size,
   output logic                  rd_go,
   output logic                  rd_en,
   output logic [NUM_LANES-1:0]  job_valid,
   output miner_pkg::line_t      job_header
);

   // a single lane still needs a one bit pointer
   localparam int PTR_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [PTR_WIDTH-1:0] ptr;
   // headers still expected in this run
   miner_pkg::count_t remaining;

   // the read channel starts together with the run
   assign rd_go   = go;
   assign rd_addr = rd_base;
   assign rd_size = size;

   // take a header only when the pointed lane can accept it right away
   assign rd_en      = !empty && lane_idle[ptr] && (remaining != '0);
   assign job_header = rd_data;

   always_comb begin
      job_valid = '0;
      if (rd_en) begin
         job_valid[ptr] = 1'b1;
      end
   end

   // the pointer restarts at lane 0 for each run so the collector stays aligned
   always_ff @(posedge clk) begin
      if (rst) begin
         ptr       <= '0;
         remaining <= '0;
      end else if (go) begin
         ptr       <= '0;
         remaining <= size;
      end else if (rd_en) begin
         remaining <= remaining - 1'b1;
         if (ptr == PTR_WIDTH'(NUM_LANES - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   // the DMA only offers data while empty is low, and a header handed on is fully defined
   assert property (@(posedge clk) disable iff (rst)
      rd_en |-> !empty && !$isunknown(rd_data));

endmodule

/* verilog/nonce_lane.sv */
// one search lane that walks the nonces of a header until one beats the target or the limit
`timescale 1ns/10ps

module nonce_lane #(
   parameter int NONCE_LIMIT = 64
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               job_valid,
   input  miner_pkg::line_t   job_header,
   input  miner_pkg::hash_t   target,
   input  logic               res_take,
   output logic               lane_idle,
   output logic               res_valid,
   output miner_pkg::line_t   res_line
);

   // the last nonce a lane tries before giving up
   localparam miner_pkg::nonce_t LAST_NONCE = miner_pkg::nonce_t'(NONCE_LIMIT - 1);

   miner_pkg::lane_state_t state;
   miner_pkg::line_t header_q;
   miner_pkg::nonce_t nonce_q;
   miner_pkg::hash_t hash;
   miner_pkg::line_t result;
   logic found;

   // ==============================
   // hash of the current nonce
   // ==============================

   // one nonce is tested per cycle, so the whole mix is combinational
   assign hash  = miner_pkg::mix_hash(header_q, nonce_q);
   assign found = hash < target;

   // on a miss at the limit the line still carries the last nonce and its hash
   always_comb begin
      result = '0;
      result[miner_pkg::RES_FOUND_BIT] = found;
      result[miner_pkg::RES_NONCE_LSB +: miner_pkg::NONCE_WIDTH] = nonce_q;
      result[miner_pkg::RES_HASH_LSB +: miner_pkg::HASH_WIDTH] = hash;
   end

   // ==============================
   // lane FSM
   // ==============================

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= miner_pkg::LANE_IDLE;
      end else begin
         case (state)
            miner_pkg::LANE_IDLE: begin
               if (job_valid) begin
                  state <= miner_pkg::LANE_SEARCH;
               end
            end
            miner_pkg::LANE_SEARCH: begin
               if (found || nonce_q == LAST_NONCE) begin
                  state <= miner_pkg::LANE_HOLD;
               end
            end
            miner_pkg::LANE_HOLD: begin
               // the collector takes the line at this edge
               if (res_take) begin
                  state <= miner_pkg::LANE_IDLE;
               end
            end
            default: state <= miner_pkg::LANE_IDLE;
         endcase
      end
   end

   // the header and nonce load with a job, and the result line is caught as the search ends
   always_ff @(posedge clk) begin
      if (state == miner_pkg::LANE_IDLE && job_valid) begin
         header_q <= job_header;
         nonce_q  <= '0;
      end else if (state == miner_pkg::LANE_SEARCH) begin
         if (found || nonce_q == LAST_NONCE) begin
            res_line <= result;
         end else begin
            nonce_q <= nonce_q + 1'b1;
         end
      end
   end

   assign lane_idle = (state == miner_pkg::LANE_IDLE);
   assign res_valid = (state == miner_pkg::LANE_HOLD);

   // the dispatcher never hands a job to a lane that is still busy
   assert property (@(posedge clk) disable iff (rst)
      job_valid |-> state == miner_pkg::LANE_IDLE);

endmodule

/* verilog/result_collect.sv */
// drains lane results in round-robin order into the DMA write channel
`timescale 1ns/10ps

module result_collect #(
   parameter int NUM_LANES = 4
) (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                go,
   input  miner_pkg::addr_t                    wr_base,
   input  miner_pkg::count_t                   size,
   input  logic [NUM_LANES-1:0]                res_valid,
   input  miner_pkg::line_t [NUM_LANES-1:0]    res_line,
   input  logic                                full,
   output miner_pkg::addr_t                    wr_addr,
   output miner_pkg::count_t                   wr_size,
   output logic                                wr_go,
   output logic                                wr_en,
   output miner_pkg::line_t                    wr_data,
   output logic [NUM_LANES-1:0]                res_take
);

   localparam int PTR_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   logic [PTR_WIDTH-1:0] ptr;

   // the write channel starts together with the read channel
   assign wr_go   = go;
   assign wr_addr = wr_base;
   assign wr_size = size;

   // waiting on the pointed lane keeps the output in header order,
   // even when a later lane finishes its search first
   assign wr_en   = res_valid[ptr] && !full;
   assign wr_data = res_line[ptr];

   always_comb begin
      res_take = '0;
      if (wr_en) begin
         res_take[ptr] = 1'b1;
      end
   end

   // same walk as the dispatcher, so both pointers meet the same lane per header
   always_ff @(posedge clk) begin
      if (rst) begin
         ptr <= '0;
      end else if (go) begin
         ptr <= '0;
      end else if (wr_en) begin
         if (ptr == PTR_WIDTH'(NUM_LANES - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

   // a full DMA must hold results back in the lanes, and a written line is fully defined
   assert property (@(posedge clk) disable iff (rst)
      wr_en |-> !full && !$isunknown(wr_data));

endmodule

/* verilog/miner.sv */
// search core that joins the dispatcher, the nonce lanes and the result collector
`timescale 1ns/10ps

module miner #(
   parameter int NUM_LANES   = 4,
   parameter int NONCE_LIMIT = 64
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               go,
   input  miner_pkg::addr_t   rd_base,
   input  miner_pkg::addr_t   wr_base,
   input  miner_pkg::count_t  size,
   input  miner_pkg::hash_t   target,
   input  miner_pkg::line_t   rd_data,
   input  logic               empty,
   input  logic               full,
   output miner_pkg::addr_t   rd_addr,
   output miner_pkg::count_t  rd_size,
   output logic               rd_go,
   output logic               rd_en,
   output miner_pkg::addr_t   wr_addr,
   output miner_pkg::count_t  wr_size,
   output logic               wr_go,
   output logic               wr_en,
   output miner_pkg::line_t   wr_data
);

   logic [NUM_LANES-1:0] lane_idle;
   logic [NUM_LANES-1:0] job_valid;
   logic [NUM_LANES-1:0] res_valid;
   logic [NUM_LANES-1:0] res_take;
   miner_pkg::line_t job_header;
   miner_pkg::line_t [NUM_LANES-1:0] res_line;
   miner_pkg::hash_t target_q;

   // the target is frozen at go, so a register write mid run leaves the lanes alone
   always_ff @(posedge clk) begin
      if (go) begin
         target_q <= target;
      end
   end

   job_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
      .clk(clk), .rst(rst), .go(go), .rd_base(rd_base), .size(size),
      .rd_data(rd_data), .empty(empty), .lane_idle(lane_idle),
      .rd_addr(rd_addr), .rd_size(rd_size), .rd_go(rd_go), .rd_en(rd_en),
      .job_valid(job_valid), .job_header(job_header)
   );

   // ==============================
   // search lanes
   // ==============================

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      nonce_lane #(.NONCE_LIMIT(NONCE_LIMIT)) u_lane (
         .clk(clk), .rst(rst), .job_valid(job_valid[i]), .job_header(job_header),
         .target(target_q), .res_take(res_take[i]), .lane_idle(lane_idle[i]),
         .res_valid(res_valid[i]), .res_line(res_line[i])
      );
   end

   result_collect #(.NUM_LANES(NUM_LANES)) u_collect (
      .clk(clk), .rst(rst), .go(go), .wr_base(wr_base), .size(size),
      .res_valid(res_valid), .res_line(res_line), .full(full),
      .wr_addr(wr_addr), .wr_size(wr_size), .wr_go(wr_go), .wr_en(wr_en),
      .wr_data(wr_data), .res_take(res_take)
   );

endmodule

/* verilog/afu.sv */
// top level of the hash search AFU, connecting the MMIO registers and the search core to the DMA
`timescale 1ns/10ps

module afu #(
   parameter int NUM_LANES   = 4,
   parameter int NONCE_LIMIT = 64
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   mmio_wr_en,
   input  miner_pkg::mmio_addr_t  mmio_wr_addr,
   input  miner_pkg::line_t       mmio_wr_data,
   input  logic                   mmio_rd_en,
   input  miner_pkg::mmio_addr_t  mmio_rd_addr,
   output miner_pkg::line_t       mmio_rd_data,
   output logic                   mmio_rd_valid,
   output miner_pkg::addr_t       rd_addr,
   output miner_pkg::count_t      rd_size,
   output logic                   rd_go,
   output logic                   rd_en,
   output miner_pkg::addr_t       wr_addr,
   output miner_pkg::count_t      wr_size,
   output logic                   wr_go,
   output logic                   wr_en,
   output miner_pkg::line_t       wr_data,
   input  miner_pkg::line_t       rd_data,
   input  logic                   empty,
   input  logic                   full,
   input  logic                   wr_done
);

   // run setup from software to the core
   logic go;
   miner_pkg::addr_t rd_base;
   miner_pkg::addr_t wr_base;
   miner_pkg::count_t size;
   miner_pkg::hash_t target;

   // done goes straight from the DMA back to software
   memory_map u_memory_map (
      .clk(clk), .rst(rst), .mmio_wr_en(mmio_wr_en), .mmio_wr_addr(mmio_wr_addr),
      .mmio_wr_data(mmio_wr_data), .mmio_rd_en(mmio_rd_en), .mmio_rd_addr(mmio_rd_addr),
      .wr_done(wr_done), .mmio_rd_data(mmio_rd_data), .mmio_rd_valid(mmio_rd_valid),
      .go(go), .rd_base(rd_base), .wr_base(wr_base), .size(size), .target(target)
   );

   miner #(.NUM_LANES(NUM_LANES), .NONCE_LIMIT(NONCE_LIMIT)) u_miner (
      .clk(clk), .rst(rst), .go(go), .rd_base(rd_base), .wr_base(wr_base),
      .size(size), .target(target), .rd_data(rd_data), .empty(empty), .full(full),
      .rd_addr(rd_addr), .rd_size(rd_size), .rd_go(rd_go), .rd_en(rd_en),
      .wr_addr(wr_addr), .wr_size(wr_size), .wr_go(wr_go), .wr_en(wr_en),
      .wr_data(wr_data)
   );

endmodule

/* testbench/host_dma_model.sv */
// host memory and DMA model for the AFU testbench, streaming headers in and capturing results
`timescale 1ns/10ps

module host_dma_model #(
   parameter int MEM_LINES = 512
) (
   input  logic               clk,
   input  logic               rst,
   input  miner_pkg::addr_t   rd_addr,
   input  miner_pkg::count_t  rd_size,
   input  logic               rd_go,
   input  logic               rd_en,
   output miner_pkg::line_t   rd_data,
   output logic               empty,
   input  miner_pkg::addr_t   wr_addr,
   input  miner_pkg::count_t  wr_size,
   input  logic               wr_go,
   input  logic               wr_en,
   input  miner_pkg::line_t   wr_data,
   output logic               full,
   output logic               wr_done,
   input  int                 gap_pct,
   input  int                 full_pct
);

   localparam int IDX_WIDTH = $clog2(MEM_LINES);

   // one shared memory holds the source headers and the destination lines
   miner_pkg::line_t mem [0:MEM_LINES-1];
   logic [IDX_WIDTH-1:0] rd_idx;
   logic [IDX_WIDTH-1:0] wr_idx;
   miner_pkg::count_t rd_left;
   miner_pkg::count_t wr_left;
   logic wr_active;

   // every line starts with a value tied to its own index
   initial begin
      for (int i = 0; i < MEM_LINES; i++) begin
         mem[i] = {32'hF111_0000 + 32'(i), 32'(i) * 32'h9E37_79B1};
      end
      rd_data = '0;
      empty   = 1'b1;
      full    = 1'b0;
      wr_done = 1'b0;
   end

   // ==============================
   // channel state on the rising edge
   // ==============================

   always @(posedge clk) begin
      if (rst) begin
         rd_idx    <= '0;
         wr_idx    <= '0;
         rd_left   <= '0;
         wr_left   <= '0;
         wr_active <= 1'b0;
      end else begin
         // byte addresses become line indices
         if (rd_go) begin
            rd_idx  <= IDX_WIDTH'(rd_addr >> 3);
            rd_left <= rd_size;
         end else if (rd_en && rd_left != '0) begin
            rd_idx  <= rd_idx + 1'b1;
            rd_left <= rd_left - 1'b1;
         end
         // extra writes still land in memory so the testbench can spot them
         if (wr_go) begin
            wr_idx    <= IDX_WIDTH'(wr_addr >> 3);
            wr_left   <= wr_size;
            wr_active <= 1'b1;
         end else if (wr_en) begin
            mem[wr_idx] <= wr_data;
            wr_idx <= wr_idx + 1'b1;
            if (wr_left != '0) begin
               wr_left <= wr_left - 1'b1;
            end
         end
      end
   end

   // ==============================
   // outputs on the falling edge
   // ==============================

   always @(negedge clk) begin
      if (rst) begin
         rd_data = '0;
         empty   = 1'b1;
         full    = 1'b0;
         wr_done = 1'b0;
      end else begin
         rd_data = mem[rd_idx];
         // random gaps hide a header that is otherwise ready
         empty   = (rd_left == '0) || (int'($urandom_range(99)) < gap_pct);
         full    = int'($urandom_range(99)) < full_pct;
         wr_done = wr_active && (wr_left == '0);
      end
   end

endmodule

/* testbench/tb_afu.sv */
// testbench top for the AFU, driving MMIO runs and checking every result line against a model
`timescale 1ns/10ps

`include "mmio_regs.svh"

module tb_afu;

   localparam int NUM_LANES   = 4;
   localparam int NONCE_LIMIT = 64;
   // each poll of the done register takes two clock cycles
   localparam int MAX_POLLS   = 4000;

   logic clk;
   logic rst;
   logic mmio_wr_en;
   miner_pkg::mmio_addr_t mmio_wr_addr;
   miner_pkg::line_t mmio_wr_data;
   logic mmio_rd_en;
   miner_pkg::mmio_addr_t mmio_rd_addr;
   miner_pkg::line_t mmio_rd_data;
   logic mmio_rd_valid;
   miner_pkg::addr_t rd_addr;
   miner_pkg::addr_t wr_addr;
   miner_pkg::count_t rd_size;
   miner_pkg::count_t wr_size;
   logic rd_go;
   logic wr_go;
   logic rd_en;
   logic wr_en;
   miner_pkg::line_t rd_data;
   miner_pkg::line_t wr_data;
   logic empty;
   logic full;
   logic wr_done;
   int gap_pct;
   int full_pct;

   // expected lines in write order, one queue for the live check and one for the slots
   miner_pkg::line_t exp_q [$];
   miner_pkg::line_t slot_q [$];
   miner_pkg::line_t cmp_expected;
   // channel setup that the next run must hand to the DMA
   miner_pkg::addr_t exp_rd_base;
   miner_pkg::addr_t exp_wr_base;
   miner_pkg::count_t exp_size;
   int start_count;
   int mmio_errors;
   int result_errors;

   afu #(.NUM_LANES(NUM_LANES), .NONCE_LIMIT(NONCE_LIMIT)) UUT (
      .clk(clk), .rst(rst), .mmio_wr_en(mmio_wr_en), .mmio_wr_addr(mmio_wr_addr),
      .mmio_wr_data(mmio_wr_data), .mmio_rd_en(mmio_rd_en), .mmio_rd_addr(mmio_rd_addr),
      .mmio_rd_data(mmio_rd_data), .mmio_rd_valid(mmio_rd_valid),
      .rd_addr(rd_addr), .rd_size(rd_size), .rd_go(rd_go), .rd_en(rd_en),
      .wr_addr(wr_addr), .wr_size(wr_size), .wr_go(wr_go), .wr_en(wr_en),
      .wr_data(wr_data), .rd_data(rd_data), .empty(empty), .full(full), .wr_done(wr_done)
   );

   host_dma_model dma (
      .clk(clk), .rst(rst), .rd_addr(rd_addr), .rd_size(rd_size), .rd_go(rd_go),
      .rd_en(rd_en), .rd_data(rd_data), .empty(empty), .wr_addr(wr_addr),
      .wr_size(wr_size), .wr_go(wr_go), .wr_en(wr_en), .wr_data(wr_data),
      .full(full), .wr_done(wr_done), .gap_pct(gap_pct), .full_pct(full_pct)
   );

   always #5 clk = ~clk;

   // ==============================
   // reference model
   // ==============================

   // nonce into the low bits, then rotate right, xor and multiply for each round
   function automatic miner_pkg::hash_t ref_hash(logic [63:0] header, logic [15:0] nonce);
      logic [63:0] v;
      v = header ^ {48'd0, nonce};
      for (int r = 0; r < miner_pkg::MIX_ROUNDS; r++) begin
         v = v ^ ((v >> miner_pkg::MIX_ROTATE) | (v << (64 - miner_pkg::MIX_ROTATE)));
         v = v * miner_pkg::MIX_MULT;
      end
      return v[31:0];
   endfunction

   // first nonce below the target wins, otherwise the last nonce and its hash are reported
   function automatic miner_pkg::line_t ref_result(logic [63:0] header, logic [31:0] target);
      logic [31:0] h;
      logic found;
      logic [63:0] res;
      found = 1'b0;
      res = '0;
      for (int n = 0; n < NONCE_LIMIT && !found; n++) begin
         h = ref_hash(header, 16'(n));
         found = h < target;
         res = {found, 15'd0, 16'(n), h};
      end
      return res;
   endfunction

   // each written line must match the next expected line at the moment it is written
   always @(posedge clk) begin
      if (!rst && wr_en) begin
         assert (exp_q.size() > 0) else begin
            $display("error: result line %h written at %0t with none expected", wr_data, $time);
            result_errors++;
         end
         if (exp_q.size() > 0) begin
            cmp_expected = exp_q.pop_front();
            assert (wr_data === cmp_expected) else begin
               $display("mismatch at %0t: result line %h, expected %h",
                        $time, wr_data, cmp_expected);
               result_errors++;
            end
         end
      end
   end

   // both DMA channels start together, once per run, with the setup of that run
   always @(posedge clk) begin
      if (!rst && (rd_go || wr_go)) begin
         start_count++;
         assert (rd_go === 1'b1 && wr_go === 1'b1) else begin
            $display("error: read and write channels did not start together at %0t", $time);
            result_errors++;
         end
         assert (rd_addr === exp_rd_base && rd_size === exp_size) else begin
            $display("mismatch at %0t: read channel %h size %0d, expected %h size %0d",
                     $time, rd_addr, rd_size, exp_rd_base, exp_size);
            result_errors++;
         end
         assert (wr_addr === exp_wr_base && wr_size === exp_size) else begin
            $display("mismatch at %0t: write channel %h size %0d, expected %h size %0d",
                     $time, wr_addr, wr_size, exp_wr_base, exp_size);
            result_errors++;
         end
      end
   end

   // ==============================
   // MMIO driver
   // ==============================

   task automatic mmio_write(miner_pkg::mmio_addr_t addr, miner_pkg::line_t data);
      @(negedge clk);
      mmio_wr_en   = 1'b1;
      mmio_wr_addr = addr;
      mmio_wr_data = data;
      @(negedge clk);
      mmio_wr_en   = 1'b0;
   endtask

   // the answer must be valid exactly one cycle after the request
   task automatic mmio_read(miner_pkg::mmio_addr_t addr, output miner_pkg::line_t data);
      @(negedge clk);
      assert (mmio_rd_valid === 1'b0) else begin
         $display("error: read answer seen without a request at %0t", $time);
         mmio_errors++;
      end
      mmio_rd_en   = 1'b1;
      mmio_rd_addr = addr;
      @(negedge clk);
      mmio_rd_en   = 1'b0;
      assert (mmio_rd_valid === 1'b1) else begin
         $display("error: no read answer one cycle after the request at %0t", $time);
         mmio_errors++;
      end
      data = mmio_rd_data;
   endtask

   task automatic read_expect(miner_pkg::mmio_addr_t addr, miner_pkg::line_t expected,
                              string what);
      miner_pkg::line_t got;
      mmio_read(addr, got);
      assert (got === expected) else begin
         $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, expected);
         mmio_errors++;
      end
   endtask

   // polls the done register and ends the run if it never rises
   task automatic wait_done();
      miner_pkg::line_t done_word;
      int polls;
      done_word = '0;
      polls = 0;
      while (done_word[0] !== 1'b1 && polls < MAX_POLLS) begin
         mmio_read(`REG_DONE, done_word);
         polls++;
      end
      if (done_word[0] !== 1'b1) begin
         $display("error: done did not rise within %0d polls at %0t", MAX_POLLS, $time);
         mmio_errors++;
         $display("mmio errors: %0d, result errors: %0d", mmio_errors, result_errors);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   endtask

   // ==============================
   // one run of headers
   // ==============================

   task automatic run_job(int src, int dst, int n, logic [31:0] target, int gaps, int fulls);
      miner_pkg::line_t header;
      for (int i = 0; i < n; i++) begin
         header = {$urandom(), $urandom()};
         dma.mem[src + i] = header;
         exp_q.push_back(ref_result(header, target));
         slot_q.push_back(ref_result(header, target));
      end
      gap_pct  = gaps;
      full_pct = fulls;
      exp_rd_base = 64'(src) * 8;
      exp_wr_base = 64'(dst) * 8;
      exp_size    = 16'(n);
      start_count = 0;
      mmio_write(`REG_RD_ADDR, 64'(src) * 8);
      mmio_write(`REG_WR_ADDR, 64'(dst) * 8);
      mmio_write(`REG_SIZE, 64'(n));
      mmio_write(`REG_TARGET, 64'(target));
      mmio_write(`REG_GO, 64'd1);
      // give wr_go time to clear the done level of the previous run
      repeat (3) @(negedge clk);
      read_expect(`REG_DONE, 64'd0, "REG_DONE during run");
      wait_done();
      assert (start_count == 1) else begin
         $display("error: the DMA channels started %0d times in one run", start_count);
         result_errors++;
      end
      assert (exp_q.size() == 0) else begin
         $display("error: %0d result lines were never written", exp_q.size());
         result_errors++;
      end
      exp_q.delete();
      // lines must sit in consecutive slots from the destination base
      for (int i = 0; i < n; i++) begin
         assert (dma.mem[dst + i] === slot_q[i]) else begin
            $display("mismatch at %0t: slot %0d holds %h, expected %h",
                     $time, dst + i, dma.mem[dst + i], slot_q[i]);
            result_errors++;
         end
      end
      slot_q.delete();
      gap_pct  = 0;
      full_pct = 0;
   endtask

   initial begin
      void'($urandom(32'h78941b2c));
      clk = 1'b0;
      rst = 1'b1;
      mmio_wr_en = 1'b0;
      mmio_wr_addr = '0;
      mmio_wr_data = '0;
      mmio_rd_en = 1'b0;
      mmio_rd_addr = '0;
      gap_pct = 0;
      full_pct = 0;
      exp_rd_base = '0;
      exp_wr_base = '0;
      exp_size = '0;
      start_count = 0;
      mmio_errors = 0;
      result_errors = 0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      // identifier and register read back
      read_expect(`REG_ID, `AFU_ID_VALUE, "REG_ID");
      mmio_write(`REG_RD_ADDR, 64'h0000_1234_5678_9A00);
      mmio_write(`REG_WR_ADDR, 64'h0000_0FED_CBA9_8700);
      mmio_write(`REG_SIZE, 64'h0000_0000_0000_BEEF);
      mmio_write(`REG_TARGET, 64'h0000_0000_CAFE_F00D);
      read_expect(`REG_RD_ADDR, 64'h0000_1234_5678_9A00, "REG_RD_ADDR");
      read_expect(`REG_WR_ADDR, 64'h0000_0FED_CBA9_8700, "REG_WR_ADDR");
      read_expect(`REG_SIZE, 64'h0000_0000_0000_BEEF, "REG_SIZE");
      read_expect(`REG_TARGET, 64'h0000_0000_CAFE_F00D, "REG_TARGET");

      // generous target, then a target nothing can beat
      run_job(0, 256, 20, 32'h2000_0000, 0, 0);
      run_job(0, 320, 20, 32'h0000_0000, 0, 0);
      // stalls on both channels with a mix of hits and misses
      run_job(64, 400, 40, 32'h0800_0000, 35, 35);
      run_job(128, 448, 12, 32'h2000_0000, 20, 20);

      repeat (2) @(negedge clk);
      $display("mmio errors: %0d, result errors: %0d", mmio_errors, result_errors);
      if (mmio_errors == 0 && result_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+include
verilog/miner_pkg.sv
verilog/memory_map.sv
verilog/job_dispatch.sv
verilog/nonce_lane.sv
verilog/result_collect.sv
verilog/miner.sv
verilog/afu.sv
testbench/host_dma_model.sv
testbench/tb_afu.sv
